//--- include/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// --------------------------------------------------
// AXI slave side
// --------------------------------------------------
`define AXI_ADDR_W 32
`define AXI_ID_W   4
`define AXI_DATA_W 64

// --------------------------------------------------
// APB master side
// --------------------------------------------------
`define APB_ADDR_W 12
`define APB_DATA_W 32 // Half of the AXI word

`endif

//--- logic/axi_apb_pkg.sv
`include "bridge_config.svh"

package axi_apb_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // One AXI data beat seen whole or as two APB words
    typedef union packed {
        logic [`AXI_DATA_W-1:0]       word;
        logic [1:0][`APB_DATA_W-1:0]  half; // half[1] is bits 63:32
    } axi_data_u;

    // --------------------------------------------------
    // AXI channel payloads
    // --------------------------------------------------
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [2:0]             size;
    } ar_req_t;

    typedef ar_req_t aw_req_t; // Same fields on the write address channel

    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        axi_data_u            data;
        axi_resp_e            resp;
    } r_rsp_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        axi_resp_e            resp;
    } b_rsp_t;

    // --------------------------------------------------
    // Sequencer to APB master link
    // --------------------------------------------------
    typedef struct packed {
        logic                   write;
        logic [`APB_ADDR_W-1:0] addr;
        logic [`APB_DATA_W-1:0] wdata;
    } apb_req_t;

    typedef struct packed {
        logic [`APB_DATA_W-1:0] rdata;
        logic                   err;   // PSLVERR of the beat
    } apb_rsp_t;

endpackage

//--- logic/axi_read_seq.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module axi_read_seq (
    input  logic                  ACLK,
    input  logic                  ARESETn,
    input  axi_apb_pkg::ar_req_t  ar_i,
    input  logic                  ar_valid_i,
    output logic                  ar_ready_o,
    output axi_apb_pkg::r_rsp_t   r_o,
    output logic                  r_valid_o,
    input  logic                  r_ready_i,
    output axi_apb_pkg::apb_req_t apb_req_o,
    output logic                  apb_req_valid_o,
    input  axi_apb_pkg::apb_rsp_t apb_rsp_i,
    input  logic                  apb_done_i
);

    typedef enum logic [1:0] {S_IDLE, S_BEAT, S_RESP} state_e;

    state_e                 state_q;
    axi_apb_pkg::ar_req_t   req_q;
    axi_apb_pkg::axi_data_u data_q;
    logic                   beat_q;    // Second beat of a 64-bit read
    logic                   err_q;
    logic                   two_beats;
    logic                   half_sel;

    assign two_beats = (req_q.size == 3'd3);
    assign half_sel  = two_beats ? beat_q : req_q.addr[2];

    assign ar_ready_o = (state_q == S_IDLE) && ar_valid_i;

    // --------------------------------------------------
    // APB request
    // --------------------------------------------------
    assign apb_req_valid_o = (state_q == S_BEAT);
    assign apb_req_o.write = 1'b0;
    assign apb_req_o.addr  = {req_q.addr[`APB_ADDR_W-1:3], half_sel, 2'b00};
    assign apb_req_o.wdata = '0;

    // R channel
    assign r_valid_o = (state_q == S_RESP);
    assign r_o.id    = req_q.id;
    assign r_o.data  = data_q;
    assign r_o.resp  = err_q ? axi_apb_pkg::SLVERR : axi_apb_pkg::OKAY;

    always_ff @(posedge ACLK, negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= S_IDLE;
            beat_q  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: if (ar_ready_o) begin
                    state_q <= S_BEAT;
                    beat_q  <= 1'b0;
                    err_q   <= 1'b0;
                end
                S_BEAT: if (apb_done_i) begin
                    err_q <= err_q | apb_rsp_i.err; // Any failing beat fails the read
                    if (two_beats && !beat_q)
                        beat_q <= 1'b1;
                    else
                        state_q <= S_RESP;
                end
                S_RESP: if (r_ready_i) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Request and read data capture
    always_ff @(posedge ACLK) begin
        if (ar_ready_o) begin
            req_q       <= ar_i;
            data_q.word <= '0; // Unused half reads as zero
        end
        if (state_q == S_BEAT && apb_done_i)
            data_q.half[half_sel] <= apb_rsp_i.rdata;
    end

endmodule

//--- logic/axi_write_seq.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module axi_write_seq (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    input  axi_apb_pkg::aw_req_t   aw_i,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  axi_apb_pkg::axi_data_u w_data_i,
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    output axi_apb_pkg::b_rsp_t    b_o,
    output logic                   b_valid_o,
    input  logic                   b_ready_i,
    output axi_apb_pkg::apb_req_t  apb_req_o,
    output logic                   apb_req_valid_o,
    input  axi_apb_pkg::apb_rsp_t  apb_rsp_i,
    input  logic                   apb_done_i
);

    typedef enum logic [1:0] {S_IDLE, S_BEAT, S_RESP} state_e;

    state_e                 state_q;
    axi_apb_pkg::aw_req_t   req_q;
    axi_apb_pkg::axi_data_u data_q;
    logic                   beat_q;
    logic                   err_q;
    logic                   accept;
    logic                   two_beats;
    logic                   half_sel;

    // AW and W are taken together
    assign accept     = (state_q == S_IDLE) && aw_valid_i && w_valid_i;
    assign aw_ready_o = accept;
    assign w_ready_o  = accept;

    assign two_beats = (req_q.size == 3'd3);
    assign half_sel  = two_beats ? beat_q : req_q.addr[2]; // Low half first

    // --------------------------------------------------
    // APB request and B channel
    // --------------------------------------------------
    assign apb_req_valid_o = (state_q == S_BEAT);
    assign apb_req_o.write = 1'b1;
    assign apb_req_o.addr  = {req_q.addr[`APB_ADDR_W-1:3], half_sel, 2'b00};
    assign apb_req_o.wdata = data_q.half[half_sel];

    assign b_valid_o = (state_q == S_RESP);
    assign b_o.id    = req_q.id;
    assign b_o.resp  = err_q ? axi_apb_pkg::SLVERR : axi_apb_pkg::OKAY;

    always_ff @(posedge ACLK, negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= S_IDLE;
            beat_q  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: if (accept) begin
                    state_q <= S_BEAT;
                    beat_q  <= 1'b0;
                    err_q   <= 1'b0;
                end
                S_BEAT: if (apb_done_i) begin
                    err_q <= err_q | apb_rsp_i.err;
                    if (two_beats && !beat_q) beat_q <= 1'b1;
                    else                      state_q <= S_RESP;
                end
                S_RESP: if (b_ready_i) state_q <= S_IDLE; // Hold B until taken
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (accept) begin
            req_q  <= aw_i;
            data_q <= w_data_i;
        end
    end

endmodule

//--- logic/apb_master.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module apb_master (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    input  axi_apb_pkg::apb_req_t  rd_req_i,
    input  logic                   rd_req_valid_i,
    output axi_apb_pkg::apb_rsp_t  rd_rsp_o,
    output logic                   rd_done_o,
    input  axi_apb_pkg::apb_req_t  wr_req_i,
    input  logic                   wr_req_valid_i,
    output axi_apb_pkg::apb_rsp_t  wr_rsp_o,
    output logic                   wr_done_o,
    output logic [`APB_ADDR_W-1:0] paddr_o,
    output logic                   psel_o,
    output logic                   penable_o,
    output logic                   pwrite_o,
    output logic [`APB_DATA_W-1:0] pwdata_o,
    input  logic [`APB_DATA_W-1:0] prdata_i,
    input  logic                   pready_i,
    input  logic                   pslverr_i
);

    typedef enum logic [1:0] {S_IDLE, S_SETUP, S_ACCESS} state_e;

    state_e                state_q;
    axi_apb_pkg::apb_req_t req_q;
    logic                  sel_wr_q;  // Side being served
    logic                  done;
    axi_apb_pkg::apb_rsp_t rsp;

    assign psel_o    = (state_q != S_IDLE);
    assign penable_o = (state_q == S_ACCESS);
    assign paddr_o   = req_q.addr;
    assign pwrite_o  = req_q.write;
    assign pwdata_o  = req_q.wdata;

    // --------------------------------------------------
    // Completion routing
    // --------------------------------------------------
    assign done      = (state_q == S_ACCESS) && pready_i;
    assign rsp.rdata = prdata_i;
    assign rsp.err   = pslverr_i;

    assign rd_done_o = done && !sel_wr_q;
    assign wr_done_o = done && sel_wr_q;
    assign rd_rsp_o  = sel_wr_q ? '0 : rsp;
    assign wr_rsp_o  = sel_wr_q ? rsp : '0;

    always_ff @(posedge ACLK, negedge ARESETn) begin
        if (!ARESETn) begin
            state_q  <= S_IDLE;
            sel_wr_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: if (rd_req_valid_i || wr_req_valid_i) begin
                    state_q  <= S_SETUP;
                    sel_wr_q <= !rd_req_valid_i; // Read wins a tie
                end
                S_SETUP:  state_q <= S_ACCESS;
                S_ACCESS: if (pready_i) state_q <= S_IDLE;
                default:  state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (state_q == S_IDLE)
            req_q <= rd_req_valid_i ? rd_req_i : wr_req_i;
    end

endmodule

//--- logic/axi_apb_bridge.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module axi_apb_bridge (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    // AXI slave port
    input  axi_apb_pkg::ar_req_t   ar_i,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    input  axi_apb_pkg::aw_req_t   aw_i,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  axi_apb_pkg::axi_data_u w_data_i,
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    output axi_apb_pkg::r_rsp_t    r_o,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    output axi_apb_pkg::b_rsp_t    b_o,
    output logic                   b_valid_o,
    input  logic                   b_ready_i,
    // APB master port
    output logic [`APB_ADDR_W-1:0] paddr_o,
    output logic                   psel_o,
    output logic                   penable_o,
    output logic                   pwrite_o,
    output logic [`APB_DATA_W-1:0] pwdata_o,
    input  logic [`APB_DATA_W-1:0] prdata_i,
    input  logic                   pready_i,
    input  logic                   pslverr_i
);

    // --------------------------------------------------
    // Sequencer to APB master links
    // --------------------------------------------------
    axi_apb_pkg::apb_req_t rd_req, wr_req;
    axi_apb_pkg::apb_rsp_t rd_rsp, wr_rsp;
    logic                  rd_req_valid, wr_req_valid;
    logic                  rd_done, wr_done;

    axi_read_seq axi_read_seq_inst (
        .ACLK, .ARESETn, .ar_i, .ar_valid_i, .ar_ready_o, .r_o, .r_valid_o, .r_ready_i,
        .apb_req_o(rd_req), .apb_req_valid_o(rd_req_valid),
        .apb_rsp_i(rd_rsp), .apb_done_i(rd_done)
    );

    axi_write_seq axi_write_seq_inst (
        .ACLK, .ARESETn, .aw_i, .aw_valid_i, .aw_ready_o, .w_data_i, .w_valid_i,
        .w_ready_o, .b_o, .b_valid_o, .b_ready_i,
        .apb_req_o(wr_req), .apb_req_valid_o(wr_req_valid),
        .apb_rsp_i(wr_rsp), .apb_done_i(wr_done)
    );

    apb_master apb_master_inst (
        .ACLK, .ARESETn,
        .rd_req_i(rd_req), .rd_req_valid_i(rd_req_valid), .rd_rsp_o(rd_rsp), .rd_done_o(rd_done),
        .wr_req_i(wr_req), .wr_req_valid_i(wr_req_valid), .wr_rsp_o(wr_rsp), .wr_done_o(wr_done),
        .paddr_o, .psel_o, .penable_o, .pwrite_o, .pwdata_o, .prdata_i, .pready_i, .pslverr_i
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o; // 8 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- test/bridge_assertions.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module bridge_assertions (
    input logic                   ACLK,
    input logic                   ARESETn,
    input logic                   ar_valid_i,
    input logic                   ar_ready_o,
    input logic                   aw_valid_i,
    input logic                   aw_ready_o,
    input logic                   r_valid_o,
    input logic                   r_ready_i,
    input logic                   b_valid_o,
    input logic                   b_ready_i,
    input logic [`APB_ADDR_W-1:0] paddr_o,
    input logic                   psel_o,
    input logic                   penable_o
);

    // --------------------------------------------------
    // AXI valid held until ready
    // --------------------------------------------------
    ar_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        ar_valid_i && !ar_ready_o |=> ar_valid_i) else $error("AR valid dropped");
    aw_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        aw_valid_i && !aw_ready_o |=> aw_valid_i) else $error("AW valid dropped");
    r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        r_valid_o && !r_ready_i |=> r_valid_o) else $error("R valid dropped");
    b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        b_valid_o && !b_ready_i |=> b_valid_o) else $error("B valid dropped");

    // --------------------------------------------------
    // APB phases
    // --------------------------------------------------
    en_after_setup: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $rose(penable_o) |-> $past(psel_o && !penable_o)) else $error("PENABLE without setup");
    en_with_sel: assert property (@(posedge ACLK) disable iff (!ARESETn)
        penable_o |-> psel_o) else $error("PENABLE without PSEL");
    addr_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        psel_o && penable_o |-> $stable(paddr_o)) else $error("PADDR moved in access");
    sel_in_reset: assert property (@(posedge ACLK)
        !ARESETn |-> !psel_o && !penable_o) else $error("PSEL high in reset");

endmodule

//--- test/tb_axi_apb_bridge.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module tb_axi_apb_bridge;

    localparam int NUM_RND  = 150; // Random writes, and as many random reads
    localparam int NUM_RDBK = 128; // Doublewords below 0x400
    localparam int NUM_TXN  = 8 + 2 * NUM_RND + NUM_RDBK; // Directed, random and read-back

    logic ACLK, ARESETn;
    axi_apb_pkg::ar_req_t   ar_i;
    axi_apb_pkg::aw_req_t   aw_i;
    axi_apb_pkg::axi_data_u w_data_i;
    axi_apb_pkg::r_rsp_t    r_o;
    axi_apb_pkg::b_rsp_t    b_o;
    logic ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o, w_valid_i, w_ready_o;
    logic r_valid_o, b_valid_o;
    logic r_ready_i = 1'b1;
    logic b_ready_i = 1'b1;
    logic [`APB_ADDR_W-1:0] paddr_o;
    logic psel_o, penable_o, pwrite_o;
    logic [`APB_DATA_W-1:0] pwdata_o;
    logic [`APB_DATA_W-1:0] prdata_i = '0;
    logic pready_i  = 1'b0;
    logic pslverr_i = 1'b0;

    logic [31:0] slave_mem [0:1023];
    logic [31:0] model_mem [0:1023]; // Reference copy of the slave memory
    axi_apb_pkg::r_rsp_t exp_r_q[$];
    axi_apb_pkg::b_rsp_t exp_b_q[$];
    int    errors = 0;
    int    checks = 0;
    int    wait_left = 0;
    logic  bp_en = 1'b0;
    string test_name = "reset";

    tb_clock_gen tb_clock_gen_inst (.clk_o(ACLK), .rst_n_o(ARESETn));

    axi_apb_bridge axi_apb_bridge_inst (.*);

    bind axi_apb_bridge bridge_assertions bridge_assertions_inst (
        .ACLK(ACLK), .ARESETn(ARESETn), .ar_valid_i(ar_valid_i), .ar_ready_o(ar_ready_o),
        .aw_valid_i(aw_valid_i), .aw_ready_o(aw_ready_o), .r_valid_o(r_valid_o),
        .r_ready_i(r_ready_i), .b_valid_o(b_valid_o), .b_ready_i(b_ready_i),
        .paddr_o(paddr_o), .psel_o(psel_o), .penable_o(penable_o)
    );

    function automatic logic [31:0] fill_word(input logic [9:0] idx);
        return {6'h2d, idx, 6'h12, ~idx};
    endfunction

    // --------------------------------------------------
    // APB slave with 0 to 3 wait states
    // --------------------------------------------------
    always @(posedge ACLK) begin
        logic fire;
        fire = 1'b0;
        if (psel_o && penable_o && pready_i) begin
            if (pwrite_o && !paddr_o[11]) slave_mem[paddr_o[11:2]] = pwdata_o;
        end else if (psel_o && !penable_o) begin
            wait_left = $urandom_range(3, 0);
            fire = (wait_left == 0);
        end else if (psel_o && penable_o) begin
            wait_left = wait_left - 1;
            fire = (wait_left == 0);
        end
        #1;
        pready_i  <= fire;
        pslverr_i <= fire && paddr_o[11];       // Upper half of the map is an error region
        prdata_i  <= fire ? slave_mem[paddr_o[11:2]] : '0;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic axi_apb_pkg::r_rsp_t expect_read(input logic [3:0] id,
            input logic [31:0] addr, input logic [2:0] size);
        axi_apb_pkg::r_rsp_t rsp;
        rsp.id        = id;
        rsp.data.word = '0;
        if (size == 3'd3) begin
            rsp.data.half[0] = model_mem[{addr[11:3], 1'b0}];
            rsp.data.half[1] = model_mem[{addr[11:3], 1'b1}];
        end else begin
            rsp.data.half[addr[2]] = model_mem[addr[11:2]];
        end
        rsp.resp = addr[11] ? axi_apb_pkg::SLVERR : axi_apb_pkg::OKAY;
        return rsp;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [2:0] size,
            input axi_apb_pkg::axi_data_u data);
        if (addr[11]) return; // Error region keeps its contents
        if (size == 3'd3) begin
            model_mem[{addr[11:3], 1'b0}] = data.half[0];
            model_mem[{addr[11:3], 1'b1}] = data.half[1];
        end else begin
            model_mem[addr[11:2]] = data.half[addr[2]];
        end
    endtask

    // --------------------------------------------------
    // AXI drivers called 1 ns after an edge
    // --------------------------------------------------
    task automatic write_txn(input logic [3:0] id, input logic [31:0] addr,
            input logic [2:0] size, input axi_apb_pkg::axi_data_u data);
        axi_apb_pkg::b_rsp_t exp;
        aw_i.id    = id;
        aw_i.addr  = addr;
        aw_i.size  = size;
        w_data_i   = data;
        aw_valid_i = 1'b1;
        w_valid_i  = 1'b1;
        forever begin
            @(posedge ACLK);
            if (w_ready_o !== aw_ready_o) begin
                errors++;
                $display("ERROR: %s AW ready and W ready differ in the same cycle", test_name);
            end
            if (aw_ready_o) break;
        end
        model_write(addr, size, data);
        exp.id   = id;
        exp.resp = addr[11] ? axi_apb_pkg::SLVERR : axi_apb_pkg::OKAY;
        exp_b_q.push_back(exp);
        #1;
        aw_valid_i = 1'b0;
        w_valid_i  = 1'b0;
    endtask

    task automatic read_txn(input logic [3:0] id, input logic [31:0] addr,
            input logic [2:0] size);
        ar_i.id    = id;
        ar_i.addr  = addr;
        ar_i.size  = size;
        ar_valid_i = 1'b1;
        @(posedge ACLK);
        while (!ar_ready_o) @(posedge ACLK);
        exp_r_q.push_back(expect_read(id, addr, size)); // Predicted at acceptance
        #1;
        ar_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_r_q.size() != 0 || exp_b_q.size() != 0) begin
            @(posedge ACLK);
            #1;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge ACLK);
            #1;
        end
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_r(input string name, input axi_apb_pkg::r_rsp_t exp,
            input axi_apb_pkg::r_rsp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s R: expected id=%h data=%h resp=%0d, actual id=%h data=%h resp=%0d",
                name, exp.id, exp.data.word, exp.resp, act.id, act.data.word, act.resp);
        end
    endtask

    task automatic check_b(input string name, input axi_apb_pkg::b_rsp_t exp,
            input axi_apb_pkg::b_rsp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s B: expected id=%h resp=%0d, actual id=%h resp=%0d",
                name, exp.id, exp.resp, act.id, act.resp);
        end
    endtask

    // Response monitors with optional back-pressure
    always @(posedge ACLK) begin
        if (ARESETn && r_valid_o && r_ready_i) begin
            if (exp_r_q.size() == 0) begin
                errors++;
                $display("ERROR: R response arrived with no read outstanding");
            end else check_r(test_name, exp_r_q.pop_front(), r_o);
        end
        #1;
        r_ready_i <= bp_en ? ($urandom_range(3, 0) != 0) : 1'b1;
    end

    always @(posedge ACLK) begin
        if (ARESETn && b_valid_o && b_ready_i) begin
            if (exp_b_q.size() == 0) begin
                errors++;
                $display("ERROR: B response arrived with no write outstanding");
            end else check_b(test_name, exp_b_q.pop_front(), b_o);
        end
        #1;
        b_ready_i <= bp_en ? ($urandom_range(3, 0) != 0) : 1'b1;
    end

    // Watchdog
    initial begin
        repeat (NUM_TXN * 64) @(posedge ACLK);
        $display("ERROR: timeout, transactions did not complete in %0d cycles", NUM_TXN * 64);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        axi_apb_pkg::axi_data_u d;
        logic [31:0] r;
        logic [2:0]  sz;
        void'($urandom(40708));
        ar_i       = '0;
        aw_i       = '0;
        w_data_i   = '0;
        ar_valid_i = 1'b0;
        aw_valid_i = 1'b0;
        w_valid_i  = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            slave_mem[i] = fill_word(10'(i));
            model_mem[i] = fill_word(10'(i));
        end
        @(posedge ARESETn);
        idle_cycles(2);

        test_name = "write64_read64";
        d.word = 64'h0123_4567_89ab_cdef;
        write_txn(4'd1, 32'h100, 3'd3, d);
        wait_idle();
        read_txn(4'd2, 32'h100, 3'd3);
        wait_idle();

        test_name = "write32_high_half";
        d.word    = {32'hcafe_f00d, 32'h1111_2222};
        write_txn(4'd3, 32'h104, 3'd2, d);
        wait_idle();
        read_txn(4'd4, 32'h100, 3'd3);
        wait_idle();

        test_name = "read32_halves";
        read_txn(4'd5, 32'h208, 3'd2);
        read_txn(4'd6, 32'h20c, 3'd2);
        wait_idle();

        test_name = "slverr";
        d.word    = 64'hdead_beef_0bad_f00d;
        write_txn(4'd7, 32'h900, 3'd3, d);
        read_txn(4'd8, 32'ha04, 3'd2);
        wait_idle();

        // Writes below 0x400, reads at 0x400 and up, so ordering between them never matters
        test_name = "random_mix";
        bp_en     = 1'b1;
        fork
            repeat (NUM_RND) begin
                idle_cycles($urandom_range(3, 0));
                r      = $urandom;
                sz     = 3'd2 + 3'($urandom_range(1, 0));
                d.word = {$urandom, $urandom};
                write_txn(4'($urandom), {20'h0, ($urandom_range(7, 0) == 0), 1'b0, r[9:3],
                    (sz == 3'd3) ? 3'b000 : {r[2], 2'b00}}, sz, d);
            end
            repeat (NUM_RND) begin
                idle_cycles($urandom_range(3, 0));
                r  = $urandom;
                sz = 3'd2 + 3'($urandom_range(1, 0));
                read_txn(4'($urandom), {20'h0, ($urandom_range(7, 0) == 0), 1'b1, r[9:3],
                    (sz == 3'd3) ? 3'b000 : {r[2], 2'b00}}, sz);
            end
        join
        wait_idle();
        bp_en = 1'b0;

        test_name = "read_back";
        for (int i = 0; i < NUM_RDBK; i++) read_txn(4'(i), {20'h0, 2'b00, 7'(i), 3'b000}, 3'd3);
        wait_idle();
        idle_cycles(4);

        if (checks != NUM_TXN) begin
            errors++;
            $display("ERROR: %0d responses were checked instead of %0d", checks, NUM_TXN);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+include
logic/axi_apb_pkg.sv
logic/axi_read_seq.sv
logic/axi_write_seq.sv
logic/apb_master.sv
logic/axi_apb_bridge.sv
test/tb_clock_gen.sv
test/bridge_assertions.sv
test/tb_axi_apb_bridge.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module tb_axi_apb_bridge -o sim_tb \
    && ./obj_dir/sim_tb | grep "RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
